// ==== Bender.yml ====
package:
  name: lc4_dual_core

sources:
  - source/lc4_pkg.sv
  - source/lc4_issue.sv
  - source/lc4_lane.sv
  - source/lc4_retire.sv
  - source/lc4_dual_core.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_lc4_dual_core.sv

// ==== project.f ====
+incdir+tb
source/lc4_pkg.sv
source/lc4_issue.sv
source/lc4_lane.sv
source/lc4_retire.sv
source/lc4_dual_core.sv
tb/tb_lc4_dual_core.sv

// ==== source/lc4_dual_core.sv ====
// two-wide lc4 alu pipeline, an independent pair retires three edges after transfer
// input ready drops only for a dependent pair, the retire ports cannot be held off
`timescale 1ns/1ps
`default_nettype none

module lc4_dual_core (
    input  logic                          gwe,
    input  logic                          i_rst,
    input  logic                          i_insn_valid,
    input  lc4_pkg::lc4_insn_t            i_insn_a,
    input  lc4_pkg::lc4_insn_t            i_insn_b,
    output logic                          o_insn_ready,
    output logic                          o_wb_valid_a,
    output logic [lc4_pkg::REG_IDX_W-1:0] o_wb_rd_a,
    output logic [lc4_pkg::XLEN-1:0]      o_wb_data_a,
    output logic                          o_wb_valid_b,
    output logic [lc4_pkg::REG_IDX_W-1:0] o_wb_rd_b,
    output logic [lc4_pkg::XLEN-1:0]      o_wb_data_b
);
    import lc4_pkg::*;

    logic [NUM_LANES-1:0]                 lane_valid;
    lc4_insn_t [NUM_LANES-1:0]            lane_insn;
    logic [NUM_LANES-1:0][XLEN-1:0]       lane_rs_data;
    logic [NUM_LANES-1:0][XLEN-1:0]       lane_rt_data;
    logic [NUM_LANES-1:0]                 lane_we;
    logic [NUM_LANES-1:0][REG_IDX_W-1:0]  lane_rd;
    logic [NUM_LANES-1:0][XLEN-1:0]       lane_result;

    logic [REG_IDX_W-1:0] rf_rs_a;
    logic [REG_IDX_W-1:0] rf_rt_a;
    logic [REG_IDX_W-1:0] rf_rs_b;
    logic [REG_IDX_W-1:0] rf_rt_b;
    logic [XLEN-1:0]      rf_rs_data_a;
    logic [XLEN-1:0]      rf_rt_data_a;
    logic [XLEN-1:0]      rf_rs_data_b;
    logic [XLEN-1:0]      rf_rt_data_b;

    lc4_issue lc4_issue_i (
        .gwe            (gwe),
        .i_rst          (i_rst),
        .i_insn_valid   (i_insn_valid),
        .i_insn_a       (i_insn_a),
        .i_insn_b       (i_insn_b),
        .o_insn_ready   (o_insn_ready),
        .i_lane_we      (lane_we),
        .i_lane_rd      (lane_rd),
        .i_lane_result  (lane_result),
        .o_rf_rs_a      (rf_rs_a),
        .o_rf_rt_a      (rf_rt_a),
        .o_rf_rs_b      (rf_rs_b),
        .o_rf_rt_b      (rf_rt_b),
        .i_rf_rs_data_a (rf_rs_data_a),
        .i_rf_rt_data_a (rf_rt_data_a),
        .i_rf_rs_data_b (rf_rs_data_b),
        .i_rf_rt_data_b (rf_rt_data_b),
        .o_lane_valid   (lane_valid),
        .o_lane_insn    (lane_insn),
        .o_lane_rs_data (lane_rs_data),
        .o_lane_rt_data (lane_rt_data)
    );

    // lane 0 carries the older instruction a, lane 1 carries b
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        lc4_lane lc4_lane_i (
            .gwe       (gwe),
            .i_rst     (i_rst),
            .i_valid   (lane_valid[g]),
            .i_insn    (lane_insn[g]),
            .i_rs_data (lane_rs_data[g]),
            .i_rt_data (lane_rt_data[g]),
            .o_we      (lane_we[g]),
            .o_rd      (lane_rd[g]),
            .o_result  (lane_result[g])
        );
    end

    lc4_retire lc4_retire_i (
        .gwe          (gwe),
        .i_rst        (i_rst),
        .i_we_a       (lane_we[0]),
        .i_rd_a       (lane_rd[0]),
        .i_result_a   (lane_result[0]),
        .i_we_b       (lane_we[1]),
        .i_rd_b       (lane_rd[1]),
        .i_result_b   (lane_result[1]),
        .i_rs_a       (rf_rs_a),
        .i_rt_a       (rf_rt_a),
        .i_rs_b       (rf_rs_b),
        .i_rt_b       (rf_rt_b),
        .o_rs_data_a  (rf_rs_data_a),
        .o_rt_data_a  (rf_rt_data_a),
        .o_rs_data_b  (rf_rs_data_b),
        .o_rt_data_b  (rf_rt_data_b),
        .o_wb_valid_a (o_wb_valid_a),
        .o_wb_rd_a    (o_wb_rd_a),
        .o_wb_data_a  (o_wb_data_a),
        .o_wb_valid_b (o_wb_valid_b),
        .o_wb_rd_b    (o_wb_rd_b),
        .o_wb_data_b  (o_wb_data_b)
    );

endmodule

`default_nettype wire

// ==== source/lc4_issue.sv ====
// issue stage for the two-wide core, holds one pair and splits it when b reads a's rd
// the rd compare ignores whether a writes at all, so a nop in a can still split the pair
// operands come from lane b, then lane a, then the register file
`timescale 1ns/1ps
`default_nettype none

module lc4_issue (
    input  logic                                                  gwe,
    input  logic                                                  i_rst,
    input  logic                                                  i_insn_valid,
    input  lc4_pkg::lc4_insn_t                                    i_insn_a,
    input  lc4_pkg::lc4_insn_t                                    i_insn_b,
    output logic                                                  o_insn_ready,
    input  logic [lc4_pkg::NUM_LANES-1:0]                         i_lane_we,
    input  logic [lc4_pkg::NUM_LANES-1:0][lc4_pkg::REG_IDX_W-1:0] i_lane_rd,
    input  logic [lc4_pkg::NUM_LANES-1:0][lc4_pkg::XLEN-1:0]      i_lane_result,
    output logic [lc4_pkg::REG_IDX_W-1:0]                         o_rf_rs_a,
    output logic [lc4_pkg::REG_IDX_W-1:0]                         o_rf_rt_a,
    output logic [lc4_pkg::REG_IDX_W-1:0]                         o_rf_rs_b,
    output logic [lc4_pkg::REG_IDX_W-1:0]                         o_rf_rt_b,
    input  logic [lc4_pkg::XLEN-1:0]                              i_rf_rs_data_a,
    input  logic [lc4_pkg::XLEN-1:0]                              i_rf_rt_data_a,
    input  logic [lc4_pkg::XLEN-1:0]                              i_rf_rs_data_b,
    input  logic [lc4_pkg::XLEN-1:0]                              i_rf_rt_data_b,
    output logic [lc4_pkg::NUM_LANES-1:0]                         o_lane_valid,
    output lc4_pkg::lc4_insn_t [lc4_pkg::NUM_LANES-1:0]           o_lane_insn,
    output logic [lc4_pkg::NUM_LANES-1:0][lc4_pkg::XLEN-1:0]      o_lane_rs_data,
    output logic [lc4_pkg::NUM_LANES-1:0][lc4_pkg::XLEN-1:0]      o_lane_rt_data
);
    import lc4_pkg::*;

    // accepted pair, waiting for its slot in the issue register
    logic      pair_valid;
    logic      pair_b_only;
    lc4_insn_t pair_a;
    lc4_insn_t pair_b;

    // issue register, one slot per lane, operands are read from here
    logic [NUM_LANES-1:0]      iss_valid;
    lc4_insn_t [NUM_LANES-1:0] iss_insn;

    logic b_needs_a;
    logic split;

    // register forms read rs and rt, immediate forms rs only
    function automatic logic reads_rs(input lc4_insn_t insn);
        return (insn.rr.opcode == OP_ARITH) || (insn.rr.opcode == OP_LOGIC);
    endfunction

    function automatic logic reads_rt(input lc4_insn_t insn);
        return reads_rs(insn) && !insn.ri.imm_flag;
    endfunction

    function automatic logic [XLEN-1:0] pick_operand(
        input logic [REG_IDX_W-1:0]                src,
        input logic [XLEN-1:0]                     rf_data,
        input logic [NUM_LANES-1:0]                we,
        input logic [NUM_LANES-1:0][REG_IDX_W-1:0] rd,
        input logic [NUM_LANES-1:0][XLEN-1:0]      result
    );
        logic [XLEN-1:0] data;
        data = rf_data;
        // walk from the oldest lane so the newest match is the one kept
        for (int i = 0; i < NUM_LANES; i++) begin
            if (we[i] && (rd[i] == src)) begin
                data = result[i];
            end
        end
        return data;
    endfunction

    assign b_needs_a = (reads_rs(pair_b) && (pair_b.rr.rs == pair_a.rr.rd))
                    || (reads_rt(pair_b) && (pair_b.rr.rt == pair_a.rr.rd));

    // only a full pair splits, the leftover b never does
    assign split = pair_valid && !pair_b_only && b_needs_a;

    // the pair register drains every cycle except the split cycle
    assign o_insn_ready = !i_rst && !split;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pair_valid  <= 1'b0;
            pair_b_only <= 1'b0;
        end else if (split) begin
            pair_b_only <= 1'b1;
        end else begin
            pair_valid  <= i_insn_valid;
            pair_b_only <= 1'b0;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_insn_valid && o_insn_ready) begin
            pair_a <= i_insn_a;
            pair_b <= i_insn_b;
        end
    end

    // b keeps lane b when it goes alone, lane a stays empty that cycle
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            iss_valid <= '0;
        end else begin
            iss_valid[0] <= pair_valid && !pair_b_only;
            iss_valid[1] <= pair_valid && (pair_b_only || !b_needs_a);
        end
    end

    always_ff @(posedge gwe) begin
        iss_insn[0] <= pair_a;
        iss_insn[1] <= pair_b;
    end

    assign o_rf_rs_a = iss_insn[0].rr.rs;
    assign o_rf_rt_a = iss_insn[0].rr.rt;
    assign o_rf_rs_b = iss_insn[1].rr.rs;
    assign o_rf_rt_b = iss_insn[1].rr.rt;

    assign o_lane_valid = iss_valid;
    assign o_lane_insn  = iss_insn;

    assign o_lane_rs_data[0] = pick_operand(iss_insn[0].rr.rs, i_rf_rs_data_a,
                                            i_lane_we, i_lane_rd, i_lane_result);
    assign o_lane_rt_data[0] = pick_operand(iss_insn[0].rr.rt, i_rf_rt_data_a,
                                            i_lane_we, i_lane_rd, i_lane_result);
    assign o_lane_rs_data[1] = pick_operand(iss_insn[1].rr.rs, i_rf_rs_data_b,
                                            i_lane_we, i_lane_rd, i_lane_result);
    assign o_lane_rt_data[1] = pick_operand(iss_insn[1].rr.rt, i_rf_rt_data_b,
                                            i_lane_we, i_lane_rd, i_lane_result);

endmodule

`default_nettype wire

// ==== source/lc4_lane.sv ====
// one execute lane, computes the alu subset and registers the write for one cycle
// mul, div, mod and all non-alu opcodes leave o_we low
`timescale 1ns/1ps
`default_nettype none

module lc4_lane (
    input  logic                          gwe,
    input  logic                          i_rst,
    input  logic                          i_valid,
    input  lc4_pkg::lc4_insn_t            i_insn,
    input  logic [lc4_pkg::XLEN-1:0]      i_rs_data,
    input  logic [lc4_pkg::XLEN-1:0]      i_rt_data,
    output logic                          o_we,
    output logic [lc4_pkg::REG_IDX_W-1:0] o_rd,
    output logic [lc4_pkg::XLEN-1:0]      o_result
);
    import lc4_pkg::*;

    logic [XLEN-1:0] imm5_sext;
    logic [XLEN-1:0] imm9_sext;
    logic [XLEN-1:0] alu_result;
    logic            supported;

    assign imm5_sext = {{(XLEN-5){i_insn.ri.imm5[4]}}, i_insn.ri.imm5};
    assign imm9_sext = {{(XLEN-9){i_insn.ci.imm9[8]}}, i_insn.ci.imm9};

    always_comb begin
        supported  = 1'b1;
        alu_result = '0;
        case (i_insn.rr.opcode)
            OP_ARITH: begin
                if (i_insn.ri.imm_flag) begin
                    alu_result = i_rs_data + imm5_sext;
                end else begin
                    case (i_insn.rr.sub_op)
                        SUB_ADD: alu_result = i_rs_data + i_rt_data;
                        SUB_SUB: alu_result = i_rs_data - i_rt_data;
                        default: supported = 1'b0;
                    endcase
                end
            end
            OP_LOGIC: begin
                if (i_insn.ri.imm_flag) begin
                    alu_result = i_rs_data & imm5_sext;
                end else begin
                    case (i_insn.rr.sub_op)
                        SUB_AND: alu_result = i_rs_data & i_rt_data;
                        SUB_NOT: alu_result = ~i_rs_data;
                        SUB_OR:  alu_result = i_rs_data | i_rt_data;
                        SUB_XOR: alu_result = i_rs_data ^ i_rt_data;
                        default: supported = 1'b0;
                    endcase
                end
            end
            OP_CONST: alu_result = imm9_sext;
            default:  supported = 1'b0;
        endcase
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            o_we <= 1'b0;
        end else begin
            o_we <= i_valid && supported;
        end
    end

    always_ff @(posedge gwe) begin
        o_rd     <= i_insn.rr.rd;
        o_result <= alu_result;
    end

endmodule

`default_nettype wire

// ==== source/lc4_pkg.sv ====
// shared widths, encodings and the instruction word for the two-wide lc4 core
// only the alu subset is decoded, every other encoding is treated as a nop
`default_nettype none

package lc4_pkg;

    localparam int XLEN      = 16;
    localparam int REG_IDX_W = 3;
    localparam int REG_COUNT = 8;
    localparam int NUM_LANES = 2;

    // primary opcodes, insn[15:12]
    localparam logic [3:0] OP_ARITH = 4'b0001;
    localparam logic [3:0] OP_LOGIC = 4'b0101;
    localparam logic [3:0] OP_CONST = 4'b1001;

    // register form sub-opcodes, insn[5:3]
    // bit 5 doubles as the immediate flag, so these all have it clear
    localparam logic [2:0] SUB_ADD = 3'b000;
    localparam logic [2:0] SUB_SUB = 3'b010;
    localparam logic [2:0] SUB_AND = 3'b000;
    localparam logic [2:0] SUB_NOT = 3'b001;
    localparam logic [2:0] SUB_OR  = 3'b010;
    localparam logic [2:0] SUB_XOR = 3'b011;

    // register-register view
    typedef struct packed {
        logic [3:0]           opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs;
        logic [2:0]           sub_op;
        logic [REG_IDX_W-1:0] rt;
    } lc4_rr_t;

    // register-immediate view, valid when imm_flag is set
    typedef struct packed {
        logic [3:0]           opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs;
        logic                 imm_flag;
        logic [4:0]           imm5;
    } lc4_ri_t;

    // const view with the signed 9-bit immediate
    typedef struct packed {
        logic [3:0]           opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [8:0]           imm9;
    } lc4_ci_t;

    // one 16-bit word, three decodings
    typedef union packed {
        lc4_rr_t rr;
        lc4_ri_t ri;
        lc4_ci_t ci;
    } lc4_insn_t;

endpackage

`default_nettype wire

// ==== source/lc4_retire.sv ====
// register file and retire report, reads are combinational from the stored values
// a and b writing the same rd in one cycle leaves b's value
`timescale 1ns/1ps
`default_nettype none

module lc4_retire (
    input  logic                          gwe,
    input  logic                          i_rst,
    input  logic                          i_we_a,
    input  logic [lc4_pkg::REG_IDX_W-1:0] i_rd_a,
    input  logic [lc4_pkg::XLEN-1:0]      i_result_a,
    input  logic                          i_we_b,
    input  logic [lc4_pkg::REG_IDX_W-1:0] i_rd_b,
    input  logic [lc4_pkg::XLEN-1:0]      i_result_b,
    input  logic [lc4_pkg::REG_IDX_W-1:0] i_rs_a,
    input  logic [lc4_pkg::REG_IDX_W-1:0] i_rt_a,
    input  logic [lc4_pkg::REG_IDX_W-1:0] i_rs_b,
    input  logic [lc4_pkg::REG_IDX_W-1:0] i_rt_b,
    output logic [lc4_pkg::XLEN-1:0]      o_rs_data_a,
    output logic [lc4_pkg::XLEN-1:0]      o_rt_data_a,
    output logic [lc4_pkg::XLEN-1:0]      o_rs_data_b,
    output logic [lc4_pkg::XLEN-1:0]      o_rt_data_b,
    output logic                          o_wb_valid_a,
    output logic [lc4_pkg::REG_IDX_W-1:0] o_wb_rd_a,
    output logic [lc4_pkg::XLEN-1:0]      o_wb_data_a,
    output logic                          o_wb_valid_b,
    output logic [lc4_pkg::REG_IDX_W-1:0] o_wb_rd_b,
    output logic [lc4_pkg::XLEN-1:0]      o_wb_data_b
);
    import lc4_pkg::*;

    logic [REG_COUNT-1:0][XLEN-1:0] regs;

    // a is older, so its write goes first and b overrides it
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            regs <= '0;
        end else begin
            if (i_we_a) begin
                regs[i_rd_a] <= i_result_a;
            end
            if (i_we_b) begin
                regs[i_rd_b] <= i_result_b;
            end
        end
    end

    // a value written on an edge is visible to issue right after it
    assign o_rs_data_a = regs[i_rs_a];
    assign o_rt_data_a = regs[i_rt_a];
    assign o_rs_data_b = regs[i_rs_b];
    assign o_rt_data_b = regs[i_rt_b];

    // report each write in the same cycle the register file takes it
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            o_wb_valid_a <= 1'b0;
            o_wb_valid_b <= 1'b0;
        end else begin
            o_wb_valid_a <= i_we_a;
            o_wb_valid_b <= i_we_b;
        end
    end

    always_ff @(posedge gwe) begin
        o_wb_rd_a   <= i_rd_a;
        o_wb_data_a <= i_result_a;
        o_wb_rd_b   <= i_rd_b;
        o_wb_data_b <= i_result_b;
    end

endmodule

`default_nettype wire

// ==== tb/tb_lc4_model.svh ====
// program-order model of the alu subset, instruction builders and the random source
// included inside the testbench module after the lc4_pkg import
`ifndef TB_LC4_MODEL_SVH
`define TB_LC4_MODEL_SVH

logic [15:0] model_regs [8];
logic [31:0] rng_state = 32'd5;

function automatic lc4_insn_t rr_word(input logic [3:0] op, input logic [2:0] sub,
                                      input logic [2:0] rd, input logic [2:0] rs,
                                      input logic [2:0] rt);
    return {op, rd, rs, sub, rt};
endfunction

function automatic lc4_insn_t ri_word(input logic [3:0] op, input logic [2:0] rd,
                                      input logic [2:0] rs, input logic [4:0] imm);
    return {op, rd, rs, 1'b1, imm};
endfunction

function automatic lc4_insn_t const_word(input logic [2:0] rd, input logic [8:0] imm);
    return {OP_CONST, rd, imm};
endfunction

// 32-bit xorshift with shifts 13, 17, 5
function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

// returns 1 with the value to write, 0 for every encoding outside the kept subset
function automatic logic execute_reference(input lc4_insn_t insn, output logic [15:0] data);
    logic [15:0] rs;
    logic [15:0] rt;
    logic [15:0] imm5;
    rs   = model_regs[insn.rr.rs];
    rt   = model_regs[insn.rr.rt];
    imm5 = {{11{insn.ri.imm5[4]}}, insn.ri.imm5};
    data = 16'h0000;
    // bits 5:3 hold the immediate flag on top of the sub-opcode
    casez ({insn.rr.opcode, insn.rr.sub_op})
        {4'b0001, 3'b1??}: data = rs + imm5;
        {4'b0001, 3'b000}: data = rs + rt;
        {4'b0001, 3'b010}: data = rs - rt;
        {4'b0101, 3'b1??}: data = rs & imm5;
        {4'b0101, 3'b000}: data = rs & rt;
        {4'b0101, 3'b001}: data = ~rs;
        {4'b0101, 3'b010}: data = rs | rt;
        {4'b0101, 3'b011}: data = rs ^ rt;
        {4'b1001, 3'b???}: data = {{7{insn.ci.imm9[8]}}, insn.ci.imm9};
        default: return 1'b0;
    endcase
    return 1'b1;
endfunction

`endif

// ==== tb/tb_lc4_dual_core.sv ====
// testbench for the two-wide lc4 core, directed pairs followed by a random stream
// expected writes follow program order and are matched in retire order, a before b
`timescale 1ns/1ps
`default_nettype none

module tb_lc4_dual_core;
    import lc4_pkg::*;

    localparam real CLK_PERIOD     = 40.0;
    localparam int  DIRECTED_PAIRS = 22;
    localparam int  RANDOM_PAIRS   = 300;
    localparam int  TOTAL_INSNS    = 2 * (DIRECTED_PAIRS + RANDOM_PAIRS);
    localparam real WATCHDOG_NS    = TOTAL_INSNS * 4 * CLK_PERIOD + 2000.0;

    logic        gwe = 1'b0;
    logic        i_rst;
    logic        i_insn_valid;
    lc4_insn_t   i_insn_a;
    lc4_insn_t   i_insn_b;
    logic        o_insn_ready;
    logic        o_wb_valid_a;
    logic [2:0]  o_wb_rd_a;
    logic [15:0] o_wb_data_a;
    logic        o_wb_valid_b;
    logic [2:0]  o_wb_rd_b;
    logic [15:0] o_wb_data_b;

    logic [2:0]  exp_rd [$];
    logic [15:0] exp_data [$];
    int error_count = 0;
    int check_count = 0;
    int retire_count = 0;
    int push_count = 0;
    int stall_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int test_start_errors;
    int test_start_stalls;

    `include "tb_lc4_model.svh"

    lc4_dual_core lc4_dual_core_i (.*);

    always #(CLK_PERIOD / 2) gwe = ~gwe;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic compare_retire(input string lane, input logic [2:0] rd,
                                  input logic [15:0] data);
        retire_count++;
        if (exp_rd.size() == 0) begin
            $display("unexpected retirement on lane %s at %0t ns: r%0d written with %h",
                     lane, $time, rd, data);
            error_count++;
        end else begin
            check_value({"o_wb_rd_", lane}, rd, exp_rd.pop_front());
            check_value({"o_wb_data_", lane}, data, exp_data.pop_front());
        end
    endtask

    // outputs sampled on the falling edge, between updates
    always @(negedge gwe) begin
        if (!i_rst) begin
            if (!o_insn_ready) begin
                stall_count++;
            end
            if (o_wb_valid_a) begin
                compare_retire("a", o_wb_rd_a, o_wb_data_a);
            end
            if (o_wb_valid_b) begin
                compare_retire("b", o_wb_rd_b, o_wb_data_b);
            end
        end
    end

    task automatic record_insn(input lc4_insn_t insn);
        logic [15:0] data;
        if (execute_reference(insn, data)) begin
            model_regs[insn.rr.rd] = data;
            exp_rd.push_back(insn.rr.rd);
            exp_data.push_back(data);
            push_count++;
        end
    endtask

    // holds the pair until it is accepted, then runs it through the model
    // ready is sampled on the falling edge ahead of the edge that transfers
    task automatic send_pair(input lc4_insn_t a, input lc4_insn_t b);
        logic accepted;
        i_insn_valid <= 1'b1;
        i_insn_a     <= a;
        i_insn_b     <= b;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge gwe);
            accepted = o_insn_ready;
            @(posedge gwe);
        end
        record_insn(a);
        record_insn(b);
    endtask

    task automatic idle_cycles(input int n);
        i_insn_valid <= 1'b0;
        repeat (n) @(posedge gwe);
    endtask

    function automatic lc4_insn_t random_insn();
        logic [31:0] r;
        logic [3:0]  op;
        r = next_random();
        case (r[14:12])
            3'd0, 3'd1, 3'd2: op = OP_ARITH;
            3'd3, 3'd4:       op = OP_LOGIC;
            3'd5:             op = OP_CONST;
            default:          op = r[31:28];
        endcase
        return {op, r[11:0]};
    endfunction

    task automatic begin_test();
        test_start_errors = error_count;
        test_start_stalls = stall_count;
        retire_count = 0;
        push_count = 0;
    endtask

    task automatic end_test(input string name);
        int waited;
        waited = 0;
        i_insn_valid <= 1'b0;
        while (exp_rd.size() != 0 && waited < 16) begin
            @(posedge gwe);
            waited++;
        end
        if (exp_rd.size() != 0) begin
            $display("missing retirement in test %s: %0d expected writes never came out",
                     name, exp_rd.size());
            error_count++;
            exp_rd.delete();
            exp_data.delete();
        end
        // pipeline depth, so a stray late write is still seen
        repeat (4) @(posedge gwe);
        check_value("retired write count", retire_count, push_count);
        if (error_count == test_start_errors) begin
            tests_passed++;
            $display("test %s: passed, %0d writes retired", name, retire_count);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - test_start_errors);
        end
    endtask

    initial begin
        lc4_insn_t   a;
        lc4_insn_t   b;
        logic [31:0] r;
        i_rst        <= 1'b1;
        i_insn_valid <= 1'b0;
        i_insn_a     <= '0;
        i_insn_b     <= '0;
        foreach (model_regs[i]) begin
            model_regs[i] = 16'h0000;
        end

        begin_test();
        repeat (4) @(posedge gwe);
        @(negedge gwe);
        check_value("o_insn_ready", o_insn_ready, 1'b0);
        check_value("o_wb_valid_a", o_wb_valid_a, 1'b0);
        check_value("o_wb_valid_b", o_wb_valid_b, 1'b0);
        @(posedge gwe);
        i_rst <= 1'b0;
        idle_cycles(4);
        check_value("o_insn_ready", o_insn_ready, 1'b1);
        send_pair(rr_word(OP_ARITH, SUB_ADD, 2, 0, 1), rr_word(OP_ARITH, SUB_ADD, 2, 0, 1));
        end_test("reset");

        begin_test();
        send_pair(const_word(1, 171), const_word(2, -100));
        send_pair(rr_word(OP_ARITH, SUB_ADD, 3, 1, 2), rr_word(OP_ARITH, SUB_SUB, 4, 1, 2));
        send_pair(rr_word(OP_LOGIC, SUB_AND, 5, 1, 2), rr_word(OP_LOGIC, SUB_OR, 6, 1, 2));
        send_pair(rr_word(OP_LOGIC, SUB_XOR, 7, 1, 2), rr_word(OP_LOGIC, SUB_NOT, 0, 1, 1));
        send_pair(ri_word(OP_ARITH, 3, 1, -7), ri_word(OP_LOGIC, 4, 2, -16));
        send_pair(ri_word(OP_ARITH, 5, 2, 15), ri_word(OP_LOGIC, 6, 1, 5));
        send_pair(const_word(7, -256), const_word(0, 255));
        end_test("independent pairs");

        begin_test();
        send_pair(const_word(1, 10), rr_word(OP_ARITH, SUB_ADD, 2, 1, 1));
        send_pair(ri_word(OP_ARITH, 4, 2, 3), rr_word(OP_ARITH, SUB_SUB, 5, 1, 4));
        send_pair(rr_word(OP_LOGIC, SUB_NOT, 6, 5, 0), rr_word(OP_LOGIC, SUB_XOR, 7, 6, 2));
        send_pair(ri_word(OP_LOGIC, 1, 7, -1), rr_word(OP_LOGIC, SUB_OR, 0, 3, 1));
        // a mul in lane a writes nothing, yet its rd field still splits the pair
        send_pair(rr_word(OP_ARITH, 3'b001, 2, 1, 1), ri_word(OP_ARITH, 3, 2, 1));
        // a split holds ready low for exactly one cycle
        idle_cycles(2);
        check_value("o_insn_ready low cycles", stall_count - test_start_stalls, 5);
        end_test("dependent pairs");

        begin_test();
        send_pair(const_word(1, 5), const_word(2, -3));
        send_pair(rr_word(OP_ARITH, SUB_ADD, 3, 1, 2), rr_word(OP_ARITH, SUB_SUB, 4, 1, 2));
        send_pair(rr_word(OP_LOGIC, SUB_XOR, 5, 3, 4), rr_word(OP_LOGIC, SUB_OR, 6, 4, 3));
        send_pair(rr_word(OP_LOGIC, SUB_AND, 7, 5, 6), ri_word(OP_ARITH, 1, 6, -1));
        end_test("bypass across pairs");

        begin_test();
        send_pair(const_word(1, 11), const_word(1, 22));
        send_pair(ri_word(OP_ARITH, 2, 1, 0), rr_word(OP_ARITH, SUB_ADD, 3, 1, 1));
        // branch, jmp, div and mod encodings
        send_pair(16'h0A05, 16'hC1C0);
        send_pair(rr_word(OP_ARITH, 3'b011, 4, 1, 1), 16'hA0F3);
        send_pair(rr_word(OP_LOGIC, SUB_XOR, 4, 1, 0), ri_word(OP_LOGIC, 5, 1, -1));
        end_test("same rd and nops");

        begin_test();
        for (int n = 0; n < RANDOM_PAIRS; n++) begin
            a = random_insn();
            b = random_insn();
            send_pair(a, b);
            r = next_random();
            if (r[1:0] == 2'b00) begin
                idle_cycles(1 + r[3:2]);
            end
        end
        end_test("random stream");

        $display("%0d tests passed, %0d failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, check_count, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0.0f ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
